//--- vlog.f
rtl/accum_arith_pkg.sv
rtl/accum_cmd_pkg.sv
rtl/accumulator_binary.sv
rtl/command_decoder.sv
rtl/accumulator_bank.sv
tb/clock_gen.sv
tb/accumulator_bank_tb.sv

//--- Makefile
# Verilator flow for the accumulator bank

VERILATOR  := verilator
TOP        := accumulator_bank_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT  := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run output is kept in a shell variable, printed, then searched
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/accumulator_bank_tb.sv
// testbench for the accumulator bank
// drives commands on the rising edge, keeps a reference model of every
// channel and checks value and overflow two cycles after each command
// covers reset state, load and add, both saturation limits, clear and NOP,
// and a long random mix of commands

`timescale 1ns/1ps

module accumulator_bank_tb import accum_arith_pkg::*, accum_cmd_pkg::*; ();

    localparam int                    WORD_WIDTH    = DEFAULT_WORD_WIDTH;
    localparam int                    NUM_CHANNELS  = 4;
    localparam logic [WORD_WIDTH-1:0] INITIAL_VALUE = '0;
    localparam bit                    SATURATING    = 1'b1;
    localparam int                    CHAN_WIDTH    = $clog2(NUM_CHANNELS);

    // each test length counts issued cycles and includes the closing sweep
    // over all channels
    localparam int ADD_RUN        = 16;
    localparam int RANDOM_RUN     = 200;
    localparam int TOTAL_COMMANDS = NUM_CHANNELS
                                  + (1 + ADD_RUN + NUM_CHANNELS)
                                  + (4 + NUM_CHANNELS)
                                  + (4 + NUM_CHANNELS)
                                  + (7 + NUM_CHANNELS)
                                  + (RANDOM_RUN + NUM_CHANNELS);
    localparam int CYCLE_LIMIT    = 2 * TOTAL_COMMANDS + 100;

    logic                    clock;
    logic                    rst;
    logic                    cmd_valid;
    logic [OP_WIDTH-1:0]     cmd_op;
    logic [CHAN_WIDTH-1:0]   cmd_channel;
    logic [WORD_WIDTH-1:0]   cmd_operand;
    logic [CHAN_WIDTH-1:0]   read_channel = '0;
    logic [WORD_WIDTH-1:0]   value;
    logic [NUM_CHANNELS-1:0] overflow;

    // the reference model keeps one word and one flag per channel
    logic [WORD_WIDTH-1:0]   model_value [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] model_flag;

    // pending checks hold one entry per issued cycle
    int                      chk_cycle_q [$];
    logic [CHAN_WIDTH-1:0]   chk_channel_q [$];
    logic [WORD_WIDTH-1:0]   exp_value_q [$];
    logic [NUM_CHANNELS-1:0] exp_flags_q [$];

    logic [CHAN_WIDTH-1:0]   check_channel;
    logic [WORD_WIDTH-1:0]   check_value;
    logic [NUM_CHANNELS-1:0] check_flags;

    logic [15:0] lfsr_state;
    int          cycle = 0;
    int          issued;
    int          checks;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;

    clock_gen #(
        .PERIOD_NS    (4.0),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    accumulator_bank #(
        .WORD_WIDTH    (WORD_WIDTH),
        .NUM_CHANNELS  (NUM_CHANNELS),
        .INITIAL_VALUE (INITIAL_VALUE),
        .SATURATING    (SATURATING)
    ) UUT (
        .clock        (clock),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_channel  (cmd_channel),
        .cmd_operand  (cmd_operand),
        .read_channel (read_channel),
        .value        (value),
        .overflow     (overflow)
    );

    // 16 bit Galois LFSR with taps 0xB400, shifted right one bit per step
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 16'hB400;
        end
        return shifted;
    endfunction

    // collects count random bits, stepping the LFSR once for every bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // applies one command to a channel of the model and returns {flag, value}
    // an add is done on exact integers and then compared with the limits
    function automatic logic [WORD_WIDTH:0] apply_command(
        input logic [OP_WIDTH-1:0]   op,
        input logic [WORD_WIDTH-1:0] old_value,
        input logic                  old_flag,
        input logic [WORD_WIDTH-1:0] operand
    );
        longint                exact;
        longint                limit_hi;
        longint                limit_lo;
        logic [WORD_WIDTH-1:0] new_value;
        logic                  new_flag;
        limit_hi  = word_max_of(WORD_WIDTH);
        limit_lo  = word_min_of(WORD_WIDTH);
        new_value = old_value;
        new_flag  = old_flag;
        case (op)
            OP_CLEAR: begin
                new_value = INITIAL_VALUE;
                new_flag  = 1'b0;
            end
            OP_LOAD: begin
                new_value = operand;
                new_flag  = 1'b0;
            end
            OP_ADD: begin
                exact     = longint'($signed(old_value)) + longint'($signed(operand));
                new_value = exact[WORD_WIDTH-1:0];
                new_flag  = (exact > limit_hi) || (exact < limit_lo);
                if (SATURATING && exact > limit_hi) begin
                    new_value = limit_hi[WORD_WIDTH-1:0];
                end else if (SATURATING && exact < limit_lo) begin
                    new_value = limit_lo[WORD_WIDTH-1:0];
                end
            end
            default: begin
                // NOP leaves the channel alone
            end
        endcase
        return {new_flag, new_value};
    endfunction

    // drives one cycle of input and queues what the named channel must show
    // two edges later
    // a cycle with valid low only checks the channel
    task automatic issue(
        input logic                  valid,
        input logic [OP_WIDTH-1:0]   op,
        input logic [CHAN_WIDTH-1:0] channel,
        input logic [WORD_WIDTH-1:0] operand
    );
        logic [WORD_WIDTH:0] result;
        @(posedge clock);
        cmd_valid   <= valid;
        cmd_op      <= op;
        cmd_channel <= channel;
        cmd_operand <= operand;
        if (valid) begin
            result = apply_command(op, model_value[channel], model_flag[channel], operand);
            model_value[channel] = result[WORD_WIDTH-1:0];
            model_flag[channel]  = result[WORD_WIDTH];
        end
        chk_cycle_q.push_back(cycle + 2);
        chk_channel_q.push_back(channel);
        exp_value_q.push_back(model_value[channel]);
        exp_flags_q.push_back(model_flag);
        issued++;
    endtask

    task automatic check_idle(input int channel);
        issue(1'b0, OP_NOP, CHAN_WIDTH'(channel), '0);
    endtask

    // reads every channel once with no command in flight, which also
    // leaves cmd_valid low at the end of a test
    task automatic check_all_channels();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            check_idle(ch);
        end
    endtask

    // waits for the last queued check and prints one line for the test
    task automatic finish_test(input string name);
        while (chk_cycle_q.size() != 0) @(posedge clock);
        @(posedge clock);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // the checker picks the channel on the edge where the result lands and
    // samples at the falling edge, where the read path has settled
    always @(posedge clock) begin
        if (chk_cycle_q.size() != 0 && chk_cycle_q[0] == cycle) begin
            check_channel = chk_channel_q.pop_front();
            check_value   = exp_value_q.pop_front();
            check_flags   = exp_flags_q.pop_front();
            chk_cycle_q.delete(0);
            read_channel <= check_channel;
            @(negedge clock);
            checks++;
            if (value !== check_value) begin
                errors++;
                $display("error: value on channel %0d expected %h, actual %h",
                         check_channel, check_value, value);
            end
            if (overflow !== check_flags) begin
                errors++;
                $display("error: overflow expected %h, actual %h", check_flags, overflow);
            end
        end
    end

    // cycle counter and run limit
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0]           bits;
        logic [OP_WIDTH-1:0]   op;
        logic [CHAN_WIDTH-1:0] channel;
        logic [WORD_WIDTH-1:0] operand;
        cmd_valid   = 1'b0;
        cmd_op      = OP_NOP;
        cmd_channel = '0;
        cmd_operand = '0;
        lfsr_state  = 16'd78;
        issued      = 0;
        checks      = 0;
        errors      = 0;
        tests_run   = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            model_value[ch] = INITIAL_VALUE;
        end
        model_flag = '0;
        // rst is only known to be high from the first rising edge on
        @(posedge clock);
        while (rst) @(posedge clock);

        check_all_channels();
        finish_test("reset state");

        // small signed operands keep the running sum well inside the range
        bits = take_bits(10);
        issue(1'b1, OP_LOAD, 1, WORD_WIDTH'($signed(bits[9:0])));
        for (int n = 0; n < ADD_RUN; n++) begin
            bits = take_bits(10);
            issue(1'b1, OP_ADD, 1, WORD_WIDTH'($signed(bits[9:0])));
        end
        check_all_channels();
        finish_test("load and add");

        // the flag is still up one idle cycle later and drops on the load
        issue(1'b1, OP_LOAD, 2, 16'h7FF0);
        issue(1'b1, OP_ADD, 2, 16'h0020);
        check_idle(2);
        issue(1'b1, OP_LOAD, 2, 16'h1234);
        check_all_channels();
        finish_test("positive saturation");

        // 0x8010 minus 16 lands exactly on 0x8000 and one more step down
        // goes past it
        issue(1'b1, OP_LOAD, 3, 16'h8010);
        issue(1'b1, OP_ADD, 3, 16'hFFF0);
        issue(1'b1, OP_ADD, 3, 16'hFFFF);
        check_idle(3);
        check_all_channels();
        finish_test("negative saturation");

        issue(1'b1, OP_LOAD, 0, 16'h7FFF);
        issue(1'b1, OP_ADD, 0, 16'h0001);
        issue(1'b1, OP_CLEAR, 0, 16'hFFFF);
        issue(1'b1, OP_LOAD, 0, 16'h0555);
        issue(1'b1, OP_NOP, 0, 16'hABCD);
        issue(1'b1, OP_NOP, 1, 16'h1111);
        // an add with valid low must be ignored
        issue(1'b0, OP_ADD, 0, 16'h0100);
        check_all_channels();
        finish_test("clear and nop");

        for (int n = 0; n < RANDOM_RUN; n++) begin
            op      = OP_WIDTH'(take_bits(OP_WIDTH));
            channel = CHAN_WIDTH'(take_bits(CHAN_WIDTH));
            operand = WORD_WIDTH'(take_bits(WORD_WIDTH));
            issue(1'b1, op, channel, operand);
        end
        check_all_channels();
        finish_test("random mix");

        $display("tests %0d, failed %0d, cycles issued %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, issued, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb/clock_gen.sv
// clock and reset source for the accumulator bank testbench
// runs a free clock of PERIOD_NS and holds rst high for the first
// RESET_CYCLES rising edges

`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clock = ~clock;
        end
    end

    // rst drops on a rising edge, just like any other synchronous input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

//--- rtl/accumulator_bank.sv
// bank of signed accumulators behind a command interface
// a registered decoder turns each command into per-channel strobes, and
// one accumulator per channel applies them, so a command shows in value
// and overflow two edges after it is sampled
// any channel is read back combinationally and all overflow flags come
// out together

`timescale 1ns/1ps

module accumulator_bank import accum_arith_pkg::*, accum_cmd_pkg::*; #(
    parameter int                    WORD_WIDTH    = DEFAULT_WORD_WIDTH,
    parameter int                    NUM_CHANNELS  = 4,
    parameter logic [WORD_WIDTH-1:0] INITIAL_VALUE = '0,
    parameter bit                    SATURATING    = 1'b0,
    localparam int                   CHAN_WIDTH    = (NUM_CHANNELS > 1) ?
                                                     $clog2(NUM_CHANNELS) : 1
) (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  logic [OP_WIDTH-1:0]     cmd_op,
    input  logic [CHAN_WIDTH-1:0]   cmd_channel,
    input  logic [WORD_WIDTH-1:0]   cmd_operand,
    input  logic [CHAN_WIDTH-1:0]   read_channel,
    output logic [WORD_WIDTH-1:0]   value,
    output logic [NUM_CHANNELS-1:0] overflow
);

    logic [NUM_CHANNELS-1:0] add_strobe;
    logic [NUM_CHANNELS-1:0] load_strobe;
    logic [NUM_CHANNELS-1:0] clear_strobe;
    logic [WORD_WIDTH-1:0]   operand_q;
    logic [WORD_WIDTH-1:0]   channel_value [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] channel_overflow;

    // first stage, the command becomes registered one-hot strobes
    command_decoder #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .WORD_WIDTH   (WORD_WIDTH)
    ) u_decoder (
        .clock        (clock),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_channel  (cmd_channel),
        .cmd_operand  (cmd_operand),
        .add_strobe   (add_strobe),
        .load_strobe  (load_strobe),
        .clear_strobe (clear_strobe),
        .operand_q    (operand_q)
    );

    // second stage, each channel applies its own strobe bit
    // the registered operand serves as both the increment and the load value
    generate
        for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
            accumulator_binary #(
                .WORD_WIDTH        (WORD_WIDTH),
                .INITIAL_VALUE     (INITIAL_VALUE),
                .SATURATING        (SATURATING)
            ) u_accumulator (
                .clock             (clock),
                .rst               (rst),
                .clear             (clear_strobe[i]),
                .increment         (operand_q),
                .increment_valid   (add_strobe[i]),
                .load_value        (operand_q),
                .load_valid        (load_strobe[i]),
                .accumulated_value (channel_value[i]),
                .signed_overflow   (channel_overflow[i])
            );
        end
    endgenerate

    // read multiplexer, a channel number past the bank reads as zero
    always_comb begin
        value = '0;
        if (int'(read_channel) < NUM_CHANNELS) begin
            value = channel_value[read_channel];
        end
    end

    // every channel's flag, bit i for channel i
    assign overflow = channel_overflow;

endmodule

//--- rtl/command_decoder.sv
// command decoder for the accumulator bank
// samples each command and turns its operation and channel into one-hot
// add, load and clear strobes, registered together with the operand
// the strobes appear one cycle after the command

`timescale 1ns/1ps

module command_decoder import accum_arith_pkg::*, accum_cmd_pkg::*; #(
    parameter int   NUM_CHANNELS = 4,
    parameter int   WORD_WIDTH   = DEFAULT_WORD_WIDTH,
    localparam int  CHAN_WIDTH   = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  logic [OP_WIDTH-1:0]     cmd_op,
    input  logic [CHAN_WIDTH-1:0]   cmd_channel,
    input  logic [WORD_WIDTH-1:0]   cmd_operand,
    output logic [NUM_CHANNELS-1:0] add_strobe,
    output logic [NUM_CHANNELS-1:0] load_strobe,
    output logic [NUM_CHANNELS-1:0] clear_strobe,
    output logic [WORD_WIDTH-1:0]   operand_q
);

    logic [NUM_CHANNELS-1:0] channel_onehot;
    logic [NUM_CHANNELS-1:0] add_next;
    logic [NUM_CHANNELS-1:0] load_next;
    logic [NUM_CHANNELS-1:0] clear_next;

    // a channel number past the bank shifts out of the one-hot vector and
    // leaves nothing set
    assign channel_onehot = NUM_CHANNELS'(1) << cmd_channel;

    // only one of the three vectors can carry the channel bit, since the
    // operation code picks exactly one of them
    always_comb begin
        add_next   = '0;
        load_next  = '0;
        clear_next = '0;
        if (cmd_valid) begin
            case (cmd_op)
                OP_ADD:   add_next   = channel_onehot;
                OP_LOAD:  load_next  = channel_onehot;
                OP_CLEAR: clear_next = channel_onehot;
                OP_NOP:   ;
                default:  ;
            endcase
        end
    end

    // the strobes fall to zero on reset, so no channel acts right after it
    always_ff @(posedge clock) begin
        if (rst) begin
            add_strobe   <= '0;
            load_strobe  <= '0;
            clear_strobe <= '0;
        end else begin
            add_strobe   <= add_next;
            load_strobe  <= load_next;
            clear_strobe <= clear_next;
        end
    end

    // the operand is captured with each valid command and is shared by
    // every channel alongside the strobes
    always_ff @(posedge clock) begin
        if (cmd_valid) begin
            operand_q <= cmd_operand;
        end
    end

    // the accumulators rely on never seeing two kinds of strobe together
    a_single_strobe_kind : assert property (
        @(posedge clock) disable iff (rst)
            $onehot0({|add_strobe, |load_strobe, |clear_strobe}))
        else $error("more than one strobe vector raised at once");

    // a command must name a channel that exists in the bank
    a_channel_in_range : assert property (
        @(posedge clock) disable iff (rst)
            cmd_valid |-> (int'(cmd_channel) < NUM_CHANNELS))
        else $error("command names channel %0d of %0d", cmd_channel, NUM_CHANNELS);

endmodule

//--- rtl/accumulator_binary.sv
// signed binary accumulator
// adds an increment to a stored word in two's complement, or loads a new
// word, or clears back to INITIAL_VALUE
// signed overflow is found by rebuilding the carry into the top bit
// the word either wraps or saturates at its limits, and the overflow flag
// stays up until the next operation on this accumulator

`timescale 1ns/1ps

module accumulator_binary import accum_arith_pkg::*; #(
    parameter int                    WORD_WIDTH    = DEFAULT_WORD_WIDTH,
    parameter logic [WORD_WIDTH-1:0] INITIAL_VALUE = '0,
    parameter bit                    SATURATING    = 1'b0
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  clear,
    input  logic [WORD_WIDTH-1:0] increment,
    input  logic                  increment_valid,
    input  logic [WORD_WIDTH-1:0] load_value,
    input  logic                  load_valid,
    output logic [WORD_WIDTH-1:0] accumulated_value,
    output logic                  signed_overflow
);

    // the signed limits, taken from the package helpers at full width and
    // cut down to the word
    localparam logic signed [MAX_WORD_WIDTH-1:0] LIMIT_MAX = word_max_of(WORD_WIDTH);
    localparam logic signed [MAX_WORD_WIDTH-1:0] LIMIT_MIN = word_min_of(WORD_WIDTH);
    localparam logic [WORD_WIDTH-1:0] WORD_MAX = LIMIT_MAX[WORD_WIDTH-1:0];
    localparam logic [WORD_WIDTH-1:0] WORD_MIN = LIMIT_MIN[WORD_WIDTH-1:0];

    logic [WORD_WIDTH-1:0] sum;
    logic                  carry_out;
    logic                  carry_into_msb;
    logic                  overflow_detected;
    logic [WORD_WIDTH-1:0] add_result;

    // plain unsigned add, one bit wider so the carry out of the top bit
    // falls into its own signal
    always_comb begin
        {carry_out, sum} = {1'b0, accumulated_value} + {1'b0, increment};
    end

    // the sum bit of the top position is a ^ b ^ carry_in, so xoring the
    // two operand sign bits with the sum sign bit gives back the carry in
    assign carry_into_msb = accumulated_value[WORD_WIDTH-1]
                          ^ increment[WORD_WIDTH-1]
                          ^ sum[WORD_WIDTH-1];

    // a carry into the top bit that differs from the carry out of it means
    // the signed result did not fit
    // landing exactly on a limit keeps both carries equal, so no flag
    assign overflow_detected = (carry_into_msb != carry_out);

    // pick what an add writes into the register
    generate
        if (SATURATING) begin : g_saturate
            // on overflow the sign of the increment says which way we went
            // past the range: a non-negative increment ran off the top
            always_comb begin
                if (!overflow_detected) begin
                    add_result = sum;
                end else if (!increment[WORD_WIDTH-1]) begin
                    add_result = WORD_MAX;
                end else begin
                    add_result = WORD_MIN;
                end
            end

            // a saturating add that overflowed has to leave the word sitting
            // on one of the two limits on the following cycle
            property p_saturate_to_limit;
                @(posedge clock) disable iff (rst)
                    (increment_valid && !load_valid && !clear && overflow_detected)
                    |=> (accumulated_value == WORD_MAX || accumulated_value == WORD_MIN);
            endproperty

            a_saturate_to_limit : assert property (p_saturate_to_limit)
                else $error("saturating add left value %h off the limits",
                            accumulated_value);
        end else begin : g_wrap
            // wrapping mode just keeps the low bits of the sum
            always_comb begin
                add_result = sum;
            end
        end
    endgenerate

    // the value register and the overflow flag share one priority chain
    // reset and clear win, then load, then add
    // with no strobe both registers hold, which is what keeps the flag up
    // until the next operation
    always_ff @(posedge clock) begin
        if (rst || clear) begin
            accumulated_value <= INITIAL_VALUE;
            signed_overflow   <= 1'b0;
        end else if (load_valid) begin
            accumulated_value <= load_value;
            signed_overflow   <= 1'b0;
        end else if (increment_valid) begin
            accumulated_value <= add_result;
            signed_overflow   <= overflow_detected;
        end
    end

endmodule

//--- rtl/accum_cmd_pkg.sv
// accumulator command package
// describes the command interface of the accumulator bank: the width of
// the operation field and the operation codes carried on it

package accum_cmd_pkg;

    // width of the operation field of a command
    localparam int OP_WIDTH = 2;

    // the operation codes
    // a command with OP_NOP is accepted but touches no channel
    localparam logic [OP_WIDTH-1:0] OP_NOP   = 2'd0;

    // add the operand to the named channel, with wrap or saturation
    // chosen by the bank
    localparam logic [OP_WIDTH-1:0] OP_ADD   = 2'd1;

    // write the operand into the named channel and drop its overflow flag
    localparam logic [OP_WIDTH-1:0] OP_LOAD  = 2'd2;

    // put the named channel back to its initial value and drop its flag
    localparam logic [OP_WIDTH-1:0] OP_CLEAR = 2'd3;

endpackage

//--- rtl/accum_arith_pkg.sv
// accumulator arithmetic package
// holds the default word width of the accumulator bank and the helpers
// that give the largest positive and smallest negative two's complement
// value for a word of a given width

package accum_arith_pkg;

    // default width of every accumulator channel in bits
    localparam int DEFAULT_WORD_WIDTH = 16;

    // widest word the limit helpers can describe
    // results come back sign extended to this width
    localparam int MAX_WORD_WIDTH = 64;

    // largest positive value a signed word of the given width can hold
    // for a 16 bit word this is 0x7FFF
    function automatic logic signed [MAX_WORD_WIDTH-1:0] word_max_of(input int width);
        logic signed [MAX_WORD_WIDTH-1:0] one;
        one = 1;
        return (one <<< (width - 1)) - one;
    endfunction

    // smallest negative value a signed word of the given width can hold
    // the low bits of the result are a one followed by zeros, so a 16 bit
    // slice reads as 0x8000
    function automatic logic signed [MAX_WORD_WIDTH-1:0] word_min_of(input int width);
        logic signed [MAX_WORD_WIDTH-1:0] one;
        one = 1;
        return -(one <<< (width - 1));
    endfunction

endpackage
